// File: input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port #(
    parameter int buffer_depth = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  noc_pkg::router_addr_t current_r_addr,
    input  noc_pkg::flit_t        flit_in,
    input  logic                  flit_in_we,
    input  logic                  pop,
    output logic                  credit_out,
    output noc_pkg::port_sel_t    req,
    output noc_pkg::flit_t        head_flit
);

    localparam int ptr_w = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
    localparam int cnt_w = $clog2(buffer_depth + 1);

    // circular flit buffer
    noc_pkg::flit_t   mem [buffer_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;       // flits held

    logic head_valid;
    logic do_push;
    logic do_pop;

    // routing
    noc_pkg::coord_t    cur_x;
    noc_pkg::coord_t    cur_y;
    noc_pkg::coord_t    dst_x;
    noc_pkg::coord_t    dst_y;
    noc_pkg::port_sel_t hdr_route;   // xy result for a header at the head
    noc_pkg::port_sel_t route_q;     // held for the body of the packet
    noc_pkg::port_sel_t route;

    // wrap for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] n;
        if (p == ptr_w'(buffer_depth - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    assign head_valid = (count != '0);
    assign do_push    = flit_in_we && (count != cnt_w'(buffer_depth));   // sender holds a credit
    assign do_pop     = pop && head_valid;

    assign head_flit  = mem[rd_ptr];
    assign credit_out = do_pop;     // freed slot goes back upstream this cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    assign {cur_x, cur_y} = current_r_addr;
    assign {dst_x, dst_y} = head_flit[2*noc_pkg::coord_w-1:0];   // dest in low payload bits

    // dimension order, x first then y
    // y grows toward the south edge
    always_comb begin
        hdr_route = '0;
        if (dst_x > cur_x) begin
            hdr_route[noc_pkg::port_east] = 1'b1;
        end else if (dst_x < cur_x) begin
            hdr_route[noc_pkg::port_west] = 1'b1;
        end else if (dst_y < cur_y) begin
            hdr_route[noc_pkg::port_north] = 1'b1;
        end else if (dst_y > cur_y) begin
            hdr_route[noc_pkg::port_south] = 1'b1;
        end else begin
            hdr_route[noc_pkg::port_local] = 1'b1;   // arrived
        end
    end

    // body flits reuse the header's route
    assign route = head_flit[noc_pkg::flit_hdr_bit] ? hdr_route : route_q;
    assign req   = head_valid ? route : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            route_q <= '0;
        end else if (do_pop && head_flit[noc_pkg::flit_hdr_bit]) begin
            route_q <= hdr_route;   // latched as the header leaves
        end
    end

endmodule

`default_nettype wire

// File: list.f
noc_pkg.sv
input_port.sv
switch_alloc.sv
output_port.sv
router.sv
router_assert.sv
tb_router.sv

// File: noc_pkg.sv
`default_nettype none

package noc_pkg;

    // router geometry
    localparam int num_ports = 5;   // local + four mesh neighbours

    // port numbers, also the bit index inside a port_sel_t
    localparam int port_local = 0;
    localparam int port_east  = 1;
    localparam int port_north = 2;
    localparam int port_west  = 3;
    localparam int port_south = 4;

    // mesh coordinates
    localparam int coord_w = 3;     // one of x or y

    // flit layout
    localparam int payload_w = 32;
    localparam int flit_w    = payload_w + 2;   // hdr + tail + payload

    // flag positions, both above the payload
    localparam int flit_hdr_bit  = flit_w - 1;
    localparam int flit_tail_bit = flit_w - 2;

    // one x or y value
    typedef logic [coord_w-1:0] coord_t;

    // {x, y}, x in the upper half
    // header flit carries the destination in its low payload bits
    typedef logic [2*coord_w-1:0] router_addr_t;

    // {hdr, tail, payload}
    typedef logic [flit_w-1:0] flit_t;

    // one-hot port choice, used for routes and grants
    typedef logic [num_ports-1:0] port_sel_t;

endpackage

`default_nettype wire

// File: output_port.sv
`timescale 1ns/1ps
`default_nettype none

module output_port #(
    parameter int buffer_depth = 4,
    parameter int credit_w     = 3
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  noc_pkg::port_sel_t                        grant,          // one-hot input
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] head_flit_all,
    input  logic                                      send,
    input  logic                                      credit_in,
    output logic                                      credit_ok,
    output noc_pkg::flit_t                            flit_out,
    output logic                                      flit_out_we
);

    noc_pkg::flit_t      xbar_flit;    // crossbar column for this output
    logic [credit_w-1:0] credit_cnt;   // free slots downstream

    // and-or mux, grant is one-hot or zero
    always_comb begin
        xbar_flit = '0;
        for (int i = 0; i < noc_pkg::num_ports; i++) begin
            if (grant[i]) begin
                xbar_flit = xbar_flit | head_flit_all[i];
            end
        end
    end

    // link register
    always_ff @(posedge clk) begin
        if (send) begin
            flit_out <= xbar_flit;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out_we <= 1'b0;
        end else begin
            flit_out_we <= send;   // one cycle per flit
        end
    end

    // downstream credits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= credit_w'(buffer_depth);   // downstream fifo empty
        end else begin
            case ({send, credit_in})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    if (credit_cnt != credit_w'(buffer_depth)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                default: ;   // send and return cancel out
            endcase
        end
    end

    assign credit_ok = (credit_cnt != '0);

endmodule

`default_nettype wire

// File: router.sv
`timescale 1ns/1ps
`default_nettype none

module router #(
    parameter int buffer_depth = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  noc_pkg::router_addr_t                     current_r_addr,
    // input side links
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0] flit_in_all,
    input  logic [noc_pkg::num_ports-1:0]            flit_in_we_all,
    output logic [noc_pkg::num_ports-1:0]            credit_out_all,
    // output side links
    output noc_pkg::flit_t [noc_pkg::num_ports-1:0] flit_out_all,
    output logic [noc_pkg::num_ports-1:0]            flit_out_we_all,
    input  logic [noc_pkg::num_ports-1:0]            credit_in_all
);

    localparam int np       = noc_pkg::num_ports;
    localparam int credit_w = $clog2(buffer_depth + 1);   // holds 0..buffer_depth

    noc_pkg::port_sel_t [np-1:0] req_all;        // per input
    noc_pkg::flit_t     [np-1:0] head_flit_all;
    logic               [np-1:0] head_tail_all;
    logic               [np-1:0] head_hdr_all;
    noc_pkg::port_sel_t [np-1:0] grant_all;      // per output
    logic               [np-1:0] pop_all;
    logic               [np-1:0] credit_ok_all;
    logic               [np-1:0] send_all;

    for (genvar i = 0; i < np; i++) begin : gen_in
        input_port #(
            .buffer_depth(buffer_depth)
        ) input_port_inst (
            .clk           (clk),
            .reset         (reset),
            .current_r_addr(current_r_addr),
            .flit_in       (flit_in_all[i]),
            .flit_in_we    (flit_in_we_all[i]),
            .pop           (pop_all[i]),
            .credit_out    (credit_out_all[i]),
            .req           (req_all[i]),
            .head_flit     (head_flit_all[i])
        );

        // flags of the head flit for the allocator
        assign head_tail_all[i] = head_flit_all[i][noc_pkg::flit_tail_bit];
        assign head_hdr_all[i]  = head_flit_all[i][noc_pkg::flit_hdr_bit];
    end

    switch_alloc switch_alloc_inst (
        .clk          (clk),
        .reset        (reset),
        .req_all      (req_all),
        .head_tail_all(head_tail_all),
        .head_hdr_all (head_hdr_all),
        .credit_ok_all(credit_ok_all),
        .grant_all    (grant_all),
        .pop_all      (pop_all)
    );

    for (genvar o = 0; o < np; o++) begin : gen_out
        assign send_all[o] = |(grant_all[o] & pop_all);   // granted input is popping

        output_port #(
            .buffer_depth(buffer_depth),
            .credit_w    (credit_w)
        ) output_port_inst (
            .clk          (clk),
            .reset        (reset),
            .grant        (grant_all[o]),
            .head_flit_all(head_flit_all),
            .send         (send_all[o]),
            .credit_in    (credit_in_all[o]),
            .credit_ok    (credit_ok_all[o]),
            .flit_out     (flit_out_all[o]),
            .flit_out_we  (flit_out_we_all[o])
        );
    end

endmodule

`default_nettype wire

// File: router_assert.sv
`timescale 1ns/1ps
`default_nettype none

module router_assert #(
    parameter int buffer_depth = 4
) (
    input logic                                          clk,
    input logic                                          reset,
    input noc_pkg::port_sel_t [noc_pkg::num_ports-1:0] grant_all,   // per output
    input logic [noc_pkg::num_ports-1:0]                flit_out_we_all,
    input logic [noc_pkg::num_ports-1:0]                credit_in_all
);

    localparam int np = noc_pkg::num_ports;

    for (genvar o = 0; o < np; o++) begin : gen_out
        int outstanding;   // flits on the link, credit not back yet

        // link side view of the downstream fifo
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                outstanding <= 0;
            end else begin
                outstanding <= outstanding + int'(flit_out_we_all[o])
                               - int'(credit_in_all[o]);
            end
        end

        grant_one_hot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(grant_all[o]))
            else $error("grant of output %0d names more than one input", o);

        // full downstream fifo means the counter sat at zero
        we_has_credit: assert property (@(posedge clk) disable iff (reset)
            flit_out_we_all[o] |-> outstanding < buffer_depth)
            else $error("output %0d sent with its credit counter at zero", o);
    end

    for (genvar i = 0; i < np; i++) begin : gen_in
        logic [np-1:0] granted_to;   // outputs granting this input
        for (genvar o = 0; o < np; o++) begin : gen_col
            assign granted_to[o] = grant_all[o][i];
        end
        single_output: assert property (@(posedge clk) disable iff (reset)
            $onehot0(granted_to))
            else $error("input %0d granted by two outputs", i);
    end

endmodule

bind router router_assert #(
    .buffer_depth(buffer_depth)
) router_assert_inst (
    .clk            (clk),
    .reset          (reset),
    .grant_all      (grant_all),
    .flit_out_we_all(flit_out_we_all),
    .credit_in_all  (credit_in_all)
);

`default_nettype wire

// File: router_cases.txt
# in_port dst_x dst_y flits first_word(hex) backpressure
# ports 0 local 1 east 2 north 3 west 4 south, router at x=3 y=3
0 5 3 4 10000000 0
0 1 3 3 10010000 0
0 3 1 2 10020000 0
0 3 6 5 10030000 0
0 3 3 1 10040000 0
1 0 2 4 20000000 0
1 3 3 3 20010000 0
1 3 0 6 20020000 0
2 7 7 4 30000000 0
2 3 5 3 30010000 0
2 3 3 2 30020000 0
3 6 0 5 40000000 0
3 4 4 8 40010000 1
3 3 7 1 40020000 0
4 2 4 4 50000000 0
4 5 1 3 50010000 0
4 3 2 7 50020000 1
4 3 3 4 50030000 0
0 6 6 3 10050000 0
1 7 3 2 20030000 0
2 0 0 5 30030000 0
3 3 3 3 40030000 0

// File: switch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module switch_alloc (
    input  logic                                          clk,
    input  logic                                          reset,
    input  noc_pkg::port_sel_t [noc_pkg::num_ports-1:0] req_all,      // per input
    input  logic [noc_pkg::num_ports-1:0]                head_tail_all,
    input  logic [noc_pkg::num_ports-1:0]                head_hdr_all,
    input  logic [noc_pkg::num_ports-1:0]                credit_ok_all, // per output
    output noc_pkg::port_sel_t [noc_pkg::num_ports-1:0] grant_all,    // per output
    output logic [noc_pkg::num_ports-1:0]                pop_all       // per input
);

    localparam int np    = noc_pkg::num_ports;
    localparam int idx_w = $clog2(np);

    typedef enum logic {idle, locked} alloc_state_t;

    alloc_state_t       state   [np];
    noc_pkg::port_sel_t owner   [np];   // input holding a locked output
    logic [idx_w-1:0]   last    [np];   // last winner per output
    noc_pkg::port_sel_t col_req [np];   // inputs asking for each output
    noc_pkg::port_sel_t moved   [np];   // grant that really pops this cycle

    // first requester after last_idx, wrapping around
    function automatic noc_pkg::port_sel_t rr_pick(input noc_pkg::port_sel_t r,
                                                   input logic [idx_w-1:0] last_idx);
        noc_pkg::port_sel_t pick;
        logic               found;
        int                 idx;
        pick  = '0;
        found = 1'b0;
        for (int k = 1; k <= np; k++) begin
            idx = (int'(last_idx) + k) % np;
            if (r[idx] && !found) begin
                pick[idx] = 1'b1;
                found     = 1'b1;
            end
        end
        return pick;
    endfunction

    // one-hot to index
    function automatic logic [idx_w-1:0] to_idx(input noc_pkg::port_sel_t s);
        logic [idx_w-1:0] n;
        n = '0;
        for (int i = 0; i < np; i++) begin
            if (s[i]) begin
                n = idx_w'(i);
            end
        end
        return n;
    endfunction

    always_comb begin
        pop_all = '0;
        for (int o = 0; o < np; o++) begin
            for (int i = 0; i < np; i++) begin
                col_req[o][i] = req_all[i][o];   // transpose
            end
            if (state[o] == locked) begin
                grant_all[o] = owner[o] & col_req[o];   // owner only, until its tail
            end else begin
                grant_all[o] = rr_pick(col_req[o] & head_hdr_all, last[o]);   // new packets only
            end
            moved[o] = credit_ok_all[o] ? grant_all[o] : '0;   // credit checked here once
            pop_all  = pop_all | moved[o];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int o = 0; o < np; o++) begin
                state[o] <= idle;
                owner[o] <= '0;
                last[o]  <= idx_w'(np - 1);   // input 0 first
            end
        end else begin
            for (int o = 0; o < np; o++) begin
                if (moved[o] != '0) begin
                    if (state[o] == idle) begin
                        last[o] <= to_idx(moved[o]);
                        if ((moved[o] & head_tail_all) == '0) begin   // single flit stays idle
                            state[o] <= locked;
                            owner[o] <= moved[o];
                        end
                    end else if ((moved[o] & head_tail_all) != '0) begin
                        state[o] <= idle;   // tail gone, release
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_router;

    localparam int np         = noc_pkg::num_ports;
    localparam int depth      = 4;
    localparam int max_cases  = 64;
    localparam int max_cycles = 4000;
    localparam int here_x     = 3;   // router sits at 3,3
    localparam int here_y     = 3;

    logic                    clk = 1'b0;
    logic                    reset;
    noc_pkg::router_addr_t   current_r_addr;
    noc_pkg::flit_t [np-1:0] flit_in_all;
    logic [np-1:0]           flit_in_we_all;
    logic [np-1:0]           credit_out_all;
    noc_pkg::flit_t [np-1:0] flit_out_all;
    logic [np-1:0]           flit_out_we_all;
    logic [np-1:0]           credit_in_all;
    logic [np-1:0]           pulses;

    // packet table from the cases file
    int          c_in [max_cases];
    int          c_out [max_cases];   // expected output from xy rule
    int          c_len [max_cases];
    logic [31:0] c_base [max_cases];  // header payload, dest in low bits
    int          c_bp [max_cases];
    bit          started [max_cases];
    int          n_cases = 0;
    int          n_done = 0;

    // upstream model, per input
    int send_case [np];
    int send_idx [np];
    int next_k [np];
    int gap [np];
    int credits [np];
    int written [np];
    int returned [np];   // credit_out pulses seen
    // downstream model, per output
    int recv_case [np];
    int recv_idx [np];
    int owed [np];
    int hold [np];
    int hold_flits [np];

    int errors = 0;
    int checks = 0;
    int seed;
    int cycles;

    always #2 clk = ~clk;

    router #(
        .buffer_depth(depth)
    ) router_inst (
        .clk            (clk),
        .reset          (reset),
        .current_r_addr (current_r_addr),
        .flit_in_all    (flit_in_all),
        .flit_in_we_all (flit_in_we_all),
        .credit_out_all (credit_out_all),
        .flit_out_all   (flit_out_all),
        .flit_out_we_all(flit_out_we_all),
        .credit_in_all  (credit_in_all)
    );

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // x first, y second, y grows southward
    function automatic int xy_port(input int x, input int y);
        int p;
        if (x > here_x) p = noc_pkg::port_east;
        else if (x < here_x) p = noc_pkg::port_west;
        else if (y < here_y) p = noc_pkg::port_north;
        else if (y > here_y) p = noc_pkg::port_south;
        else p = noc_pkg::port_local;
        return p;
    endfunction

    function automatic noc_pkg::flit_t exp_flit(input int k, input int idx);
        noc_pkg::flit_t f;
        f = '0;
        f[noc_pkg::flit_hdr_bit]  = (idx == 0);
        f[noc_pkg::flit_tail_bit] = (idx == c_len[k] - 1);
        f[noc_pkg::payload_w-1:0] = c_base[k] + idx;   // first word plus i
        return f;
    endfunction

    // unstarted packet for this output whose header matches
    function automatic int find_packet(input int o, input noc_pkg::flit_t f);
        int hit;
        hit = -1;
        for (int k = 0; k < n_cases; k++) begin
            if (hit < 0 && !started[k] && c_out[k] == o && exp_flit(k, 0) == f) hit = k;
        end
        return hit;
    endfunction

    task automatic load_cases();
        int          fd;
        int          p;
        int          x;
        int          y;
        int          len;
        int          bp;
        logic [31:0] first;
        string       line;
        fd = $fopen("router_cases.txt", "r");
        if (fd == 0) begin
            $display("Error: could not open router_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < max_cases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#" &&
                    $sscanf(line, "%d %d %d %d %h %d", p, x, y, len, first, bp) == 6) begin
                    c_in[n_cases]   = p;
                    c_out[n_cases]  = xy_port(x, y);
                    c_len[n_cases]  = len;
                    c_base[n_cases] = (first & ~32'h3f) | {26'd0, x[2:0], y[2:0]};
                    c_bp[n_cases]   = bp;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_inputs();
        for (int i = 0; i < np; i++) begin
            flit_in_we_all[i] = 1'b0;
            flit_in_all[i]    = '0;
            for (int k = next_k[i]; k < n_cases && send_case[i] < 0; k++) begin
                if (c_in[k] == i) begin   // next packet of this input, file order
                    send_case[i] = k;
                    send_idx[i]  = 0;
                    next_k[i]    = k + 1;
                end
            end
            if (send_case[i] >= 0) begin
                if (gap[i] > 0) begin
                    gap[i]--;
                end else if (credits[i] > 0) begin   // only with a credit in hand
                    flit_in_all[i]    = exp_flit(send_case[i], send_idx[i]);
                    flit_in_we_all[i] = 1'b1;
                    credits[i]--;
                    written[i]++;
                    send_idx[i]++;
                    gap[i] = $unsigned($random(seed)) % 3;
                    if (send_idx[i] == c_len[send_case[i]]) send_case[i] = -1;
                end
            end
        end
    endtask

    task automatic watch_outputs();
        noc_pkg::flit_t f;
        int             k;
        int             skipped;
        for (int o = 0; o < np; o++) begin
            credit_in_all[o] = 1'b0;
            if (flit_out_we_all[o]) begin
                f = flit_out_all[o];
                owed[o]++;
                if (hold[o] > 0) hold_flits[o]++;
                if (recv_case[o] < 0) begin
                    k = find_packet(o, f);
                    if (k < 0) begin
                        $display("Error: output %0d sent flit %0h outside any packet", o, f);
                        errors++;
                    end else begin
                        skipped = 0;   // earlier packet, same input and output
                        for (int j = 0; j < k; j++) begin
                            if (!started[j] && c_in[j] == c_in[k] && c_out[j] == o) skipped = 1;
                        end
                        check($sformatf("packet order case %0d", k), 0, skipped);
                        started[k]   = 1'b1;
                        recv_case[o] = k;
                        recv_idx[o]  = 0;
                        if (c_bp[k] != 0) begin
                            hold[o]       = 20;
                            hold_flits[o] = 1;   // header counts
                        end
                    end
                end
                if (recv_case[o] >= 0) begin
                    check($sformatf("case %0d flit %0d on output %0d", recv_case[o],
                                    recv_idx[o], o), exp_flit(recv_case[o], recv_idx[o]), f);
                    recv_idx[o]++;
                    if (recv_idx[o] == c_len[recv_case[o]]) begin
                        n_done++;
                        recv_case[o] = -1;
                    end
                end
            end
            // downstream credit return, one cycle after the flit
            if (hold[o] > 0) begin
                hold[o]--;
                if (hold[o] == 0) begin
                    check($sformatf("flits within buffer_depth while output %0d held", o),
                          1, hold_flits[o] <= depth);
                end
            end else if (owed[o] > 0) begin
                credit_in_all[o] = 1'b1;
                owed[o]--;
            end
        end
    endtask

    function automatic bit all_settled();
        bit ok;
        ok = (n_done == n_cases);
        for (int o = 0; o < np; o++) begin
            if (owed[o] != 0 || hold[o] != 0) ok = 1'b0;
        end
        return ok;
    endfunction

    initial begin
        seed           = 79886;
        reset          = 1'b1;
        current_r_addr = {3'(here_x), 3'(here_y)};
        flit_in_all    = '0;
        flit_in_we_all = '0;
        credit_in_all  = '0;
        for (int i = 0; i < np; i++) begin
            send_case[i] = -1;
            recv_case[i] = -1;
            next_k[i]    = 0;
            gap[i]       = 0;
            credits[i]   = depth;   // router fifo empty
            written[i]   = 0;
            returned[i]  = 0;
            owed[i]      = 0;
            hold[i]      = 0;
        end
        load_cases();
        if (n_cases == 0) begin
            $display("Error: no packet cases were loaded");
            errors++;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) begin   // nothing written yet
            @(negedge clk);
            check("flit_out_we_all after reset", 0, flit_out_we_all);
            check("credit_out_all after reset", 0, credit_out_all);
        end
        cycles = 0;
        while (!all_settled() && cycles < max_cycles) begin
            @(negedge clk);
            pulses = credit_out_all;
            drive_inputs();
            watch_outputs();
            for (int i = 0; i < np; i++) begin
                if (pulses[i]) begin   // usable from the next cycle on
                    credits[i]++;
                    returned[i]++;
                end
            end
            cycles++;
        end
        if (cycles >= max_cycles) begin
            $display("timeout: only %0d of %0d packets delivered", n_done, n_cases);
            errors++;
        end else begin
            for (int i = 0; i < np; i++) begin
                check($sformatf("credit_out total on input %0d", i), written[i], returned[i]);
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
